//--- design/arbiter_pkg.sv
// Arbiter sizes and event type
`default_nettype none

package arbiter_pkg;

    // Pixel group, level 0
    parameter int LVL0_ROWS = 4;                        // Pixel rows per group
    parameter int LVL0_COLS = 4;                        // Pixel columns per group
    parameter int LVL0_ADD  = 2;                        // Local row/column index width

    // Group grid, level 1
    parameter int LVL1_ROWS = 2;                        // Group rows
    parameter int LVL1_COLS = 2;                        // Group columns
    parameter int LVL1_ADD  = 1;                        // Group row/column index width

    // Whole array
    parameter int ARRAY_ROWS = LVL1_ROWS * LVL0_ROWS;   // 8 pixel rows
    parameter int ARRAY_COLS = LVL1_COLS * LVL0_COLS;   // 8 pixel columns
    parameter int ARRAY_ADD  = LVL1_ADD + LVL0_ADD;     // Array row/column index width

    // Address event as handed to the outside
    typedef struct packed {
        logic [ARRAY_ADD-1:0] x;                        // Array row
        logic [ARRAY_ADD-1:0] y;                        // Array column
    } pixel_event_t;

endpackage

`default_nettype wire

//--- design/scan_arbiter.sv
// Pointer scan arbiter
`timescale 1ns/100ps
`default_nettype none

module scan_arbiter #(
    parameter int WIDTH = 4,                            // Number of request lines
    parameter int ADD_W = 2                             // Index width, WIDTH == 2**ADD_W
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             enable_i,                  // Allow one step of the scan
    input  logic             refresh_i,                 // Restart the pass from line 0
    input  logic [WIDTH-1:0] req_i,
    output logic [WIDTH-1:0] gnt_o,                     // One-hot grant, held between steps
    output logic [ADD_W-1:0] add_o,                     // Index of the granted line
    output logic             grp_release_o              // Nothing left at or above the pointer
);

    logic [ADD_W:0]   ptr_q;                            // Next line to look at, WIDTH = pass done
    logic [WIDTH-1:0] above;                            // Requests still ahead of the pointer
    logic [ADD_W-1:0] pick;                             // Lowest line in above
    logic             found;

    always_comb
    begin
        above = '0;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < WIDTH; i++)
        begin
            above[i] = req_i[i] && (i >= ptr_q);        // Mask off lines already passed
        end
        // Walk downwards so the lowest hit wins
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (above[i])
            begin
                pick  = ADD_W'(i);
                found = 1'b1;
            end
        end
    end

    assign grp_release_o = ~found;                      // Pass exhausted

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q <= '0;
            gnt_o <= '0;
            add_o <= '0;
        end
        else if (refresh_i)
        begin
            ptr_q <= '0;                                // New pass
            gnt_o <= '0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                gnt_o <= WIDTH'(1) << pick;             // Grant the next line
                add_o <= pick;
                ptr_q <= {1'b0, pick} + 1'b1;           // Step past it
            end
            else
            begin
                gnt_o <= '0;                            // End of pass
            end
        end
    end

    a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o))
        else $error("scan_arbiter: more than one line granted");

endmodule

`default_nettype wire

//--- design/pixel_level_0.sv
// Level-0 pixel group arbiter
`timescale 1ns/100ps
`default_nettype none

module pixel_level_0 #(
    parameter int ROWS  = arbiter_pkg::LVL0_ROWS,       // Pixel rows in the group
    parameter int COLS  = arbiter_pkg::LVL0_COLS,       // Pixel columns in the group
    parameter int ADD_W = arbiter_pkg::LVL0_ADD         // Local index width
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      enable_i,         // Group selected by level 1
    input  logic                      hold_i,           // Event stage busy, freeze column scan
    input  logic [ROWS-1:0][COLS-1:0] req_i,            // Pixel requests of this group
    output logic [ROWS-1:0][COLS-1:0] gnt_o,            // Pixel grants, at most one
    output logic [ADD_W-1:0]          x_add_o,          // Granted local row
    output logic [ADD_W-1:0]          y_add_o,          // Granted local column
    output logic                      active_o,         // A pixel grant is present
    output logic                      grp_release_o     // Group fully served
);

    typedef enum logic [1:0] {
        IDLE      = 2'b00,                              // Not selected
        ROW_GRANT = 2'b01,                              // Looking for the next active row
        COL_GRANT = 2'b10                               // Walking the columns of one row
    } state_t;

    state_t          state_q;
    state_t          state_d;
    logic [ROWS-1:0] row_req;                           // Row has any request
    logic [COLS-1:0] col_req;                           // Requests of the selected row
    logic [ROWS-1:0] x_gnt;
    logic [COLS-1:0] y_gnt;
    logic            x_enable;
    logic            y_enable;
    logic            refresh_x;
    logic            refresh_y;
    logic            rel_x;
    logic            rel_y;

    always_comb
    begin
        for (int i = 0; i < ROWS; i++)
        begin
            row_req[i] = |req_i[i];
        end
    end

    assign col_req  = req_i[x_add_o];                   // Row picked by rra_x
    assign active_o = |y_gnt;

    // Pixel grant is the cross of row and column grant
    always_comb
    begin
        for (int i = 0; i < ROWS; i++)
        begin
            for (int j = 0; j < COLS; j++)
            begin
                gnt_o[i][j] = x_gnt[i] & y_gnt[j];
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d   = state_q;
        x_enable  = 1'b0;
        y_enable  = 1'b0;
        refresh_x = 1'b0;
        refresh_y = 1'b0;
        if (!enable_i)
        begin
            state_d   = IDLE;                           // Deselected, rewind both scans
            refresh_x = 1'b1;
            refresh_y = 1'b1;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    x_enable = 1'b1;                    // First row step
                    state_d  = ROW_GRANT;
                end
                ROW_GRANT:
                begin
                    if (x_gnt != '0)
                    begin
                        y_enable = 1'b1;                // First column of the new row
                        state_d  = COL_GRANT;
                    end
                    else
                    begin
                        x_enable = 1'b1;                // Keep looking for a row
                    end
                end
                COL_GRANT:
                begin
                    if (y_gnt == '0)
                    begin
                        x_enable  = 1'b1;               // Row finished, go to next row
                        refresh_y = 1'b1;
                        state_d   = ROW_GRANT;
                    end
                    else
                    begin
                        y_enable = ~hold_i;             // Next column once the event is out
                    end
                end
                default:
                begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    // Release only once the last pixel's grant has been taken back
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            grp_release_o <= 1'b0;
        end
        else
        begin
            grp_release_o <= enable_i & rel_x & rel_y & ~|y_gnt;
        end
    end

    scan_arbiter #(.WIDTH(ROWS), .ADD_W(ADD_W)) rra_x (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (x_enable),
        .refresh_i     (refresh_x),
        .req_i         (row_req),
        .gnt_o         (x_gnt),
        .add_o         (x_add_o),
        .grp_release_o (rel_x)
    );

    scan_arbiter #(.WIDTH(COLS), .ADD_W(ADD_W)) rra_y (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (y_enable),
        .refresh_i     (refresh_y),
        .req_i         (col_req),
        .gnt_o         (y_gnt),
        .add_o         (y_add_o),
        .grp_release_o (rel_y)
    );

    a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o))
        else $error("pixel_level_0: more than one pixel granted");

endmodule

`default_nettype wire

//--- design/group_level_1.sv
// Level-1 group selector
`timescale 1ns/100ps
`default_nettype none

module group_level_1 #(
    parameter int GROUPS  = arbiter_pkg::LVL1_ROWS * arbiter_pkg::LVL1_COLS,
    parameter int GRP_ADD = 2 * arbiter_pkg::LVL1_ADD
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic [GROUPS-1:0]  grp_req_i,               // Group has pending pixels
    input  logic [GROUPS-1:0]  grp_release_i,           // Group done, from level 0
    output logic [GROUPS-1:0]  grp_en_o,                // One-hot group enable
    output logic [GRP_ADD-1:0] grp_add_o                // Index of the selected group
);

    typedef enum logic [1:0] {
        G_IDLE  = 2'b00,                                // Step the scan or rewind it
        G_CHECK = 2'b01,                                // Look at the fresh grant
        G_BUSY  = 2'b10                                 // Group enabled, wait for release
    } gstate_t;

    gstate_t           state_q;
    gstate_t           state_d;
    logic [GROUPS-1:0] arb_gnt;
    logic              arb_enable;
    logic              arb_refresh;
    logic              arb_release;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= G_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d     = state_q;
        arb_enable  = 1'b0;
        arb_refresh = 1'b0;
        case (state_q)
            G_IDLE:
            begin
                if (arb_release)
                begin
                    arb_refresh = 1'b1;                 // Pass over, start again from group 0
                end
                else
                begin
                    arb_enable = 1'b1;
                    state_d    = G_CHECK;
                end
            end
            G_CHECK:
            begin
                state_d = (arb_gnt != '0) ? G_BUSY : G_IDLE;
            end
            G_BUSY:
            begin
                if (grp_release_i[grp_add_o])
                begin
                    state_d = G_IDLE;                   // Move on to the next group
                end
            end
            default:
            begin
                state_d = G_IDLE;
            end
        endcase
    end

    assign grp_en_o = (state_q == G_BUSY) ? arb_gnt : '0;

    scan_arbiter #(.WIDTH(GROUPS), .ADD_W(GRP_ADD)) rra_grp (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (arb_enable),
        .refresh_i     (arb_refresh),
        .req_i         (grp_req_i),
        .gnt_o         (arb_gnt),
        .add_o         (grp_add_o),
        .grp_release_o (arb_release)
    );

    a_en_onehot0: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grp_en_o))
        else $error("group_level_1: more than one group enabled");

endmodule

`default_nettype wire

//--- design/event_handshake.sv
// Address event output stage
`timescale 1ns/100ps
`default_nettype none

module event_handshake (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      pix_valid_i,      // Pixel grant present
    input  arbiter_pkg::pixel_event_t pix_event_i,      // Address of that grant
    input  logic                      ev_ack_i,
    output logic                      ev_req_o,
    output arbiter_pkg::pixel_event_t ev_o,
    output logic                      hold_o            // Freeze the column scan
);

    typedef enum logic [1:0] {
        S_IDLE = 2'b00,                                 // Waiting for a grant
        S_REQ  = 2'b01,                                 // Request up, waiting for ack
        S_ACK  = 2'b10,                                 // Request down, waiting for ack low
        S_REL  = 2'b11                                  // One cycle to let the scan step
    } hs_state_t;

    hs_state_t state_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= S_IDLE;
        end
        else
        begin
            case (state_q)
                S_IDLE:  if (pix_valid_i) state_q <= S_REQ;
                S_REQ:   if (ev_ack_i) state_q <= S_ACK;
                S_ACK:   if (!ev_ack_i) state_q <= S_REL;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (state_q == S_IDLE && pix_valid_i)
        begin
            ev_o <= pix_event_i;                        // Capture the address
        end
    end

    assign ev_req_o = (state_q == S_REQ);

    // Grant seen in idle blocks the scan before the latch takes it
    assign hold_o = (state_q == S_IDLE) ? pix_valid_i : (state_q != S_REL);

    a_ev_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        ev_req_o |=> !ev_req_o || $stable(ev_o))
        else $error("event_handshake: ev_o changed while ev_req_o high");

endmodule

`default_nettype wire

//--- design/pixel_arbiter_top.sv
// Hierarchical AER scan arbiter
`timescale 1ns/100ps
`default_nettype none

module pixel_arbiter_top #(
    parameter int LVL0_ROWS = arbiter_pkg::LVL0_ROWS,
    parameter int LVL0_COLS = arbiter_pkg::LVL0_COLS,
    parameter int LVL0_ADD  = arbiter_pkg::LVL0_ADD,
    parameter int LVL1_ROWS = arbiter_pkg::LVL1_ROWS,
    parameter int LVL1_COLS = arbiter_pkg::LVL1_COLS,
    parameter int LVL1_ADD  = arbiter_pkg::LVL1_ADD
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [LVL1_ROWS*LVL0_ROWS-1:0][LVL1_COLS*LVL0_COLS-1:0] req_i,
    input  logic                      ev_ack_i,
    output logic [LVL1_ROWS*LVL0_ROWS-1:0][LVL1_COLS*LVL0_COLS-1:0] gnt_o,
    output logic                      ev_req_o,
    output arbiter_pkg::pixel_event_t ev_o
);

    localparam int GROUPS  = LVL1_ROWS * LVL1_COLS;
    localparam int GRP_ADD = 2 * LVL1_ADD;

    logic [GROUPS-1:0]                           grp_req;
    logic [GROUPS-1:0]                           grp_en;
    logic [GROUPS-1:0]                           grp_release;
    logic [GROUPS-1:0]                           grp_active;
    logic [GRP_ADD-1:0]                          grp_add;
    logic [GROUPS-1:0][LVL0_ROWS-1:0][LVL0_COLS-1:0] grp_pix_req;
    logic [GROUPS-1:0][LVL0_ROWS-1:0][LVL0_COLS-1:0] grp_gnt;
    logic [GROUPS-1:0][LVL0_ADD-1:0]             grp_x;
    logic [GROUPS-1:0][LVL0_ADD-1:0]             grp_y;
    logic                                        hold;
    logic                                        pix_valid;
    arbiter_pkg::pixel_event_t                   pix_event;

    for (genvar gr = 0; gr < LVL1_ROWS; gr++)
    begin : g_row
        for (genvar gc = 0; gc < LVL1_COLS; gc++)
        begin : g_col
            localparam int G = gr * LVL1_COLS + gc;     // Group index, row major
            for (genvar i = 0; i < LVL0_ROWS; i++)
            begin : g_pix_row
                for (genvar j = 0; j < LVL0_COLS; j++)
                begin : g_pix_col
                    assign grp_pix_req[G][i][j] = req_i[gr*LVL0_ROWS+i][gc*LVL0_COLS+j];
                    assign gnt_o[gr*LVL0_ROWS+i][gc*LVL0_COLS+j] = grp_gnt[G][i][j];
                end
            end
            assign grp_req[G] = |grp_pix_req[G];        // Any pixel of the group pending

            pixel_level_0 #(.ROWS(LVL0_ROWS), .COLS(LVL0_COLS), .ADD_W(LVL0_ADD))
                i_pixel_level_0 (
                .clk_i         (clk_i),
                .reset_i       (reset_i),
                .enable_i      (grp_en[G]),
                .hold_i        (hold),
                .req_i         (grp_pix_req[G]),
                .gnt_o         (grp_gnt[G]),
                .x_add_o       (grp_x[G]),
                .y_add_o       (grp_y[G]),
                .active_o      (grp_active[G]),
                .grp_release_o (grp_release[G])
            );
        end
    end

    group_level_1 #(.GROUPS(GROUPS), .GRP_ADD(GRP_ADD)) i_group_level_1 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .grp_req_i     (grp_req),
        .grp_release_i (grp_release),
        .grp_en_o      (grp_en),
        .grp_add_o     (grp_add)
    );

    // Group row/col on top of local index gives row*4 + local
    assign pix_valid   = |(grp_en & grp_active);
    assign pix_event.x = {grp_add[GRP_ADD-1 -: LVL1_ADD], grp_x[grp_add]};
    assign pix_event.y = {grp_add[LVL1_ADD-1:0], grp_y[grp_add]};

    event_handshake i_event_handshake (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pix_valid_i (pix_valid),
        .pix_event_i (pix_event),
        .ev_ack_i    (ev_ack_i),
        .ev_req_o    (ev_req_o),
        .ev_o        (ev_o),
        .hold_o      (hold)
    );

endmodule

`default_nettype wire

//--- include/test_vectors.svh
// Request mask table
`ifndef TEST_VECTORS_SVH
`define TEST_VECTORS_SVH

// Bit row*8 + col is the request of array pixel (row, col)
localparam int NUM_VECTORS = 9;

localparam logic [63:0] TEST_MASKS [NUM_VECTORS] = '{
    64'h0000_0000_0000_0000,                            // Quiet array
    64'h0000_0000_0000_0001,                            // Single pixel (0,0)
    64'h0000_0000_0020_0000,                            // Single pixel (2,5)
    64'hFFFF_FFFF_FFFF_FFFF,                            // Full array, 64 events
    64'hF0F0_F0F0_0000_0000,                            // Group 3 only
    64'h0F0F_0F0F_F0F0_F0F0,                            // Groups 1 and 2
    64'h0100_0000_0000_0080,                            // Corners of groups 1 and 2
    64'hAA55_AA55_AA55_AA55,                            // Checkerboard
    64'h8040_2010_0804_0201                             // Diagonal across groups 0 and 3
};

`endif

//--- test/pixel_arbiter_tb.sv
// Testbench for the hierarchical AER scan arbiter
`timescale 1ns/100ps
`default_nettype none

module pixel_arbiter_tb;

    `include "test_vectors.svh"

    localparam int ADD_W      = arbiter_pkg::ARRAY_ADD;
    localparam int NUM_RANDOM = 6;                      // Random masks after the table
    localparam int SETTLE     = 20;                     // Quiet cycles after each mask
    localparam int BASE_CYC   = 200;                    // Budget per table entry
    localparam int EVENT_CYC  = 24;                     // Extra budget per expected event

    typedef logic [arbiter_pkg::ARRAY_ROWS-1:0][arbiter_pkg::ARRAY_COLS-1:0] pixel_map_t;

    logic                      clk_i;
    logic                      reset_i;
    pixel_map_t                req_i;
    logic                      ev_ack_i;
    pixel_map_t                gnt_o;
    logic                      ev_req_o;
    arbiter_pkg::pixel_event_t ev_o;

    arbiter_pkg::pixel_event_t exp_q [$];               // Reference order of the current mask
    arbiter_pkg::pixel_event_t held_ev;                 // ev_o seen at the rise of ev_req_o
    logic [63:0]               masks [$];
    logic [63:0]               rnd_mask;
    logic [31:0]               lcg_state;
    logic                      req_seen;                // ev_req_o in the previous cycle
    int                        ack_wait;                // Cycles before ack goes up
    int                        drop_wait;               // Cycles before ack goes down
    int                        event_count;
    int                        cycle_count;
    int                        cycle_limit;

    pixel_arbiter_top i_pixel_arbiter_top (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .ev_ack_i (ev_ack_i),
        .gnt_o    (gnt_o),
        .ev_req_o (ev_req_o),
        .ev_o     (ev_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;                      // 10 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_event(input string name, input arbiter_pkg::pixel_event_t got,
                               input arbiter_pkg::pixel_event_t exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s got (x=%0d,y=%0d) expected (x=%0d,y=%0d)",
                     $time, name, got.x, got.y, exp.x, exp.y);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_grant(input string name, input pixel_map_t got, input pixel_map_t exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Groups ascending, then rows, then columns inside a group
    task automatic build_expected(input logic [63:0] mask);
        arbiter_pkg::pixel_event_t ev;
        int row;
        int col;
        exp_q.delete();
        for (int gr = 0; gr < arbiter_pkg::LVL1_ROWS; gr++)
            for (int gc = 0; gc < arbiter_pkg::LVL1_COLS; gc++)
                for (int r = 0; r < arbiter_pkg::LVL0_ROWS; r++)
                    for (int c = 0; c < arbiter_pkg::LVL0_COLS; c++)
                    begin
                        row = gr * arbiter_pkg::LVL0_ROWS + r;
                        col = gc * arbiter_pkg::LVL0_COLS + c;
                        if (mask[row * arbiter_pkg::ARRAY_COLS + col])
                        begin
                            ev.x = ADD_W'(row);
                            ev.y = ADD_W'(col);
                            exp_q.push_back(ev);
                        end
                    end
    endtask

    // One clock of pixel model, event checks and ack model
    task automatic step_cycle();
        arbiter_pkg::pixel_event_t exp_ev;
        pixel_map_t                exp_gnt;
        @(posedge clk_i);
        #1;
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, events stopped coming", cycle_count);
            abort_run();
        end
        req_i = req_i & ~gnt_o;                         // Granted pixels drop their request
        if (ev_ack_i && ev_req_o)
        begin
            $display("Error at %0t: ev_req_o still high one cycle after ev_ack_i", $time);
            abort_run();
        end
        if (ev_req_o && !req_seen)                      // New event
        begin
            if (exp_q.size() == 0)
            begin
                $display("Error at %0t: event raised with no pixel left to serve", $time);
                abort_run();
            end
            exp_ev = exp_q.pop_front();
            check_event("ev_o", ev_o, exp_ev);
            exp_gnt = '0;
            exp_gnt[exp_ev.x][exp_ev.y] = 1'b1;
            check_grant("gnt_o", gnt_o, exp_gnt);
            held_ev = ev_o;
            event_count++;
            ack_wait  = int'((lcg_next() >> 16) % 6);   // Slow acks give back-pressure
            drop_wait = int'((lcg_next() >> 16) % 3);
        end
        else if (ev_req_o)
        begin
            check_event("ev_o held", ev_o, held_ev);
        end
        req_seen = ev_req_o;
        if (ev_req_o && !ev_ack_i)
        begin
            if (ack_wait == 0)
                ev_ack_i = 1'b1;
            else
                ack_wait--;
        end
        else if (!ev_req_o && ev_ack_i)
        begin
            if (drop_wait == 0)
                ev_ack_i = 1'b0;                        // Handshake closes
            else
                drop_wait--;
        end
    endtask

    task automatic run_vector(input logic [63:0] mask);
        int expected;
        build_expected(mask);
        expected    = exp_q.size();
        event_count = 0;
        req_i       = mask;                             // Array is quiet here
        while (req_i != '0 || gnt_o != '0 || ev_req_o || ev_ack_i)
            step_cycle();                               // Until every pixel is served
        repeat (SETTLE) step_cycle();                   // No extra events allowed
        check_count("event count", event_count, expected);
        check_grant("gnt_o idle", gnt_o, '0);
    endtask

    initial
    begin
        $timeformat(-9, 1, " ns", 0);
        reset_i     = 1'b1;
        req_i       = '0;
        ev_ack_i    = 1'b0;
        req_seen    = 1'b0;
        ack_wait    = 0;
        drop_wait   = 0;
        event_count = 0;
        cycle_count = 0;
        lcg_state   = 32'd50;                           // Seed
        for (int i = 0; i < NUM_VECTORS; i++)
            masks.push_back(TEST_MASKS[i]);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rnd_mask = {lcg_next(), lcg_next()};
            if (i % 2 == 1)
                rnd_mask = rnd_mask & {lcg_next(), lcg_next()};   // Sparser mask
            masks.push_back(rnd_mask);
        end
        cycle_limit = 0;
        foreach (masks[i])
            cycle_limit += BASE_CYC + EVENT_CYC * $countones(masks[i]);
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        foreach (masks[i])
            run_vector(masks[i]);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
design/arbiter_pkg.sv
design/scan_arbiter.sv
design/pixel_level_0.sv
design/group_level_1.sv
design/event_handshake.sv
design/pixel_arbiter_top.sv
test/pixel_arbiter_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module pixel_arbiter_tb \
    -o sim_tb > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1
if [ ! -f sim.log ] || grep -q -F '** FAIL **' sim.log || ! grep -q -F '** PASS **' sim.log; then
    echo "Simulation failed, see build.log and sim.log"
    exit 1
fi
echo "Simulation passed"
